// File: hw/axil_pkg.sv
package axil_pkg;

  // AXI-Lite bus geometry
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // W channel payload
  typedef struct packed {
    data_t data;
    strb_t strb;
  } axil_w_t;

  // Work order handed to the memory port
  // The writeback fields only matter when a writeback is started
  typedef struct packed {
    addr_t wb_addr;
    data_t wb_data;
    addr_t fill_addr;
  } mem_cmd_t;

endpackage

// File: hw/cache_cfg_pkg.sv
package cache_cfg_pkg;

  import axil_pkg::*;

  // Byte offset inside one word
  localparam int OFFSET_BITS = 2;

  // Controller states
  typedef enum logic [1:0] {
    AVAILABLE       = 2'd0,
    AWAIT_WRITEBACK = 2'd1,
    AWAIT_FILL      = 2'd2,
    AWAIT_RESPONSE  = 2'd3
  } cache_state_t;

  // What the store reports for the set selected by the lookup address
  typedef struct packed {
    logic  hit;
    logic  victim_dirty;
    addr_t victim_addr;
    data_t data;
  } line_info_t;

endpackage

// File: hw/cache_store.sv
`timescale 1ns/1ps

module cache_store import axil_pkg::*, cache_cfg_pkg::*; #(
  parameter int num_sets = 4
) (
  input  logic       ACLK,
  input  logic       ARESETn,
  input  addr_t      lookup_addr,
  input  logic       wr_en,
  input  axil_w_t    wr_payload,
  input  logic       fill_en,
  input  data_t      fill_word,
  output line_info_t line
);

  localparam int index_bits = $clog2(num_sets);
  localparam int tag_bits   = ADDR_W - index_bits - OFFSET_BITS;

  data_t               data_q  [num_sets];
  logic [tag_bits-1:0] tag_q   [num_sets];
  logic [num_sets-1:0] valid_q;
  logic [num_sets-1:0] dirty_q;

  logic [index_bits-1:0] idx;
  logic [tag_bits-1:0]   addr_tag;

  // Replace only the bytes whose strobe is set
  function automatic data_t merge_bytes(data_t old_word, axil_w_t payload);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (payload.strb[b]) begin
        merged[8*b +: 8] = payload.data[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // Address split: tag | index | byte offset
  assign idx      = lookup_addr[OFFSET_BITS +: index_bits];
  assign addr_tag = lookup_addr[ADDR_W-1 -: tag_bits];

  always_comb begin
    line.hit          = valid_q[idx] && (tag_q[idx] == addr_tag);
    line.victim_dirty = valid_q[idx] && dirty_q[idx];
    // Rebuild the address of whatever currently occupies the set
    line.victim_addr  = {tag_q[idx], idx, {OFFSET_BITS{1'b0}}};
    line.data         = data_q[idx];
  end

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      valid_q <= '0;
    end else if (fill_en) begin
      valid_q[idx] <= 1'b1;
    end
  end

  always_ff @(posedge ACLK) begin
    if (fill_en) begin
      // A fill for a write miss folds the buffered bytes in on the same edge
      if (wr_en) begin
        data_q[idx] <= merge_bytes(fill_word, wr_payload);
      end else begin
        data_q[idx] <= fill_word;
      end
      tag_q[idx]   <= addr_tag;
      dirty_q[idx] <= wr_en;
    end else if (wr_en) begin
      data_q[idx]  <= merge_bytes(data_q[idx], wr_payload);
      dirty_q[idx] <= 1'b1;
    end
  end

endmodule

// File: hw/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import axil_pkg::*, cache_cfg_pkg::*; (
  input  logic       ACLK,
  input  logic       ARESETn,
  // Processor side
  input  logic       ar_valid,
  output logic       ar_ready,
  input  addr_t      ar_addr,
  output logic       r_valid,
  input  logic       r_ready,
  output data_t      r_data,
  input  logic       aw_valid,
  output logic       aw_ready,
  input  addr_t      aw_addr,
  input  logic       w_valid,
  output logic       w_ready,
  input  axil_w_t    w,
  output logic       b_valid,
  input  logic       b_ready,
  // Store
  input  line_info_t line,
  output addr_t      lookup_addr,
  output logic       wr_en,
  output axil_w_t    wr_payload,
  output logic       fill_en,
  output data_t      fill_word,
  // Memory port
  input  logic       wb_done,
  input  logic       fill_done,
  input  data_t      fill_data,
  output logic       start_wb,
  output logic       start_fill,
  output mem_cmd_t   cmd
);

  cache_state_t state_q;

  addr_t   miss_addr_q;
  logic    miss_is_read_q;
  axil_w_t wr_buf_q;

  logic idle;
  logic rd_req;
  logic wr_req;
  logic req_miss;
  logic fill_now;
  logic resp_done;

  assign idle = (state_q == AVAILABLE);

  // One request in flight, so every ready simply follows the idle state
  assign ar_ready = idle;
  assign aw_ready = idle;
  assign w_ready  = idle;

  // Read wins when both arrive together
  assign rd_req   = idle && ar_valid;
  assign wr_req   = idle && !ar_valid && aw_valid && w_valid;
  assign req_miss = (rd_req || wr_req) && !line.hit;

  assign fill_now  = (state_q == AWAIT_FILL) && fill_done;
  assign resp_done = (r_valid && r_ready) || (b_valid && b_ready);

  always_comb begin
    if (!idle) begin
      lookup_addr = miss_addr_q;
    end else if (ar_valid) begin
      lookup_addr = ar_addr;
    end else begin
      lookup_addr = aw_addr;
    end
  end

  // Store write strobes
  assign wr_en      = (wr_req && line.hit) || (fill_now && !miss_is_read_q);
  assign wr_payload = idle ? w : wr_buf_q;
  assign fill_en    = fill_now;
  assign fill_word  = fill_data;

  // Dirty victim goes out first, the fill follows once it is acknowledged
  assign start_wb   = req_miss && line.victim_dirty;
  assign start_fill = (req_miss && !line.victim_dirty)
                    || ((state_q == AWAIT_WRITEBACK) && wb_done);

  // The set is untouched until the fill, so the victim fields stay valid
  always_comb begin
    cmd.wb_addr   = line.victim_addr;
    cmd.wb_data   = line.data;
    cmd.fill_addr = {lookup_addr[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  end

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      state_q        <= AVAILABLE;
      r_valid        <= 1'b0;
      b_valid        <= 1'b0;
      miss_is_read_q <= 1'b0;
    end else begin
      case (state_q)
        AVAILABLE: begin
          if (rd_req || wr_req) begin
            if (line.hit) begin
              r_valid <= rd_req;
              b_valid <= wr_req;
              state_q <= AWAIT_RESPONSE;
            end else begin
              miss_is_read_q <= rd_req;
              state_q        <= line.victim_dirty ? AWAIT_WRITEBACK : AWAIT_FILL;
            end
          end
        end
        AWAIT_WRITEBACK: begin
          if (wb_done) begin
            state_q <= AWAIT_FILL;
          end
        end
        AWAIT_FILL: begin
          if (fill_done) begin
            r_valid <= miss_is_read_q;
            b_valid <= !miss_is_read_q;
            state_q <= AWAIT_RESPONSE;
          end
        end
        AWAIT_RESPONSE: begin
          // Hold the response until the processor takes it
          if (resp_done) begin
            r_valid <= 1'b0;
            b_valid <= 1'b0;
            state_q <= AVAILABLE;
          end
        end
        default: state_q <= AVAILABLE;
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if (rd_req || wr_req) begin
      miss_addr_q <= lookup_addr;
      wr_buf_q    <= w;
    end
    // Read data comes from the hit line or straight from the fill
    if (rd_req && line.hit) begin
      r_data <= line.data;
    end else if (fill_now) begin
      r_data <= fill_data;
    end
  end

endmodule

// File: hw/mem_port.sv
`timescale 1ns/1ps

module mem_port import axil_pkg::*; (
  input  logic     ACLK,
  input  logic     ARESETn,
  input  logic     start_wb,
  input  logic     start_fill,
  input  mem_cmd_t cmd,
  output logic     wb_done,
  output logic     fill_done,
  output data_t    fill_data,
  // AXI-Lite manager toward memory
  output logic     mem_ar_valid,
  input  logic     mem_ar_ready,
  output addr_t    mem_ar_addr,
  input  logic     mem_r_valid,
  output logic     mem_r_ready,
  input  data_t    mem_r_data,
  output logic     mem_aw_valid,
  input  logic     mem_aw_ready,
  output addr_t    mem_aw_addr,
  output logic     mem_w_valid,
  input  logic     mem_w_ready,
  output axil_w_t  mem_w,
  input  logic     mem_b_valid,
  output logic     mem_b_ready
);

  logic ar_fire;
  logic r_fire;
  logic aw_fire;
  logic w_fire;
  logic b_fire;

  assign ar_fire = mem_ar_valid && mem_ar_ready;
  assign r_fire  = mem_r_valid && mem_r_ready;
  assign aw_fire = mem_aw_valid && mem_aw_ready;
  assign w_fire  = mem_w_valid && mem_w_ready;
  assign b_fire  = mem_b_valid && mem_b_ready;

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      mem_aw_valid <= 1'b0;
      mem_w_valid  <= 1'b0;
      mem_b_ready  <= 1'b0;
      mem_ar_valid <= 1'b0;
      mem_r_ready  <= 1'b0;
      wb_done      <= 1'b0;
      fill_done    <= 1'b0;
    end else begin
      wb_done   <= b_fire;
      fill_done <= r_fire;

      // AW and W may be accepted in different cycles
      if (start_wb) begin
        mem_aw_valid <= 1'b1;
        mem_w_valid  <= 1'b1;
        mem_b_ready  <= 1'b1;
      end else begin
        if (aw_fire) begin
          mem_aw_valid <= 1'b0;
        end
        if (w_fire) begin
          mem_w_valid <= 1'b0;
        end
        if (b_fire) begin
          mem_b_ready <= 1'b0;
        end
      end

      if (start_fill) begin
        mem_ar_valid <= 1'b1;
        mem_r_ready  <= 1'b1;
      end else begin
        if (ar_fire) begin
          mem_ar_valid <= 1'b0;
        end
        if (r_fire) begin
          mem_r_ready <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (start_wb) begin
      mem_aw_addr <= cmd.wb_addr;
      mem_w.data  <= cmd.wb_data;
      mem_w.strb  <= '1;  // whole word goes back
    end
    if (start_fill) begin
      mem_ar_addr <= cmd.fill_addr;
    end
    if (r_fire) begin
      fill_data <= mem_r_data;
    end
  end

endmodule

// File: hw/axil_cache.sv
`timescale 1ns/1ps

module axil_cache import axil_pkg::*, cache_cfg_pkg::*; #(
  parameter int num_sets = 4
) (
  input  logic    ACLK,
  input  logic    ARESETn,
  // Processor side
  input  logic    ar_valid,
  output logic    ar_ready,
  input  addr_t   ar_addr,
  output logic    r_valid,
  input  logic    r_ready,
  output data_t   r_data,
  input  logic    aw_valid,
  output logic    aw_ready,
  input  addr_t   aw_addr,
  input  logic    w_valid,
  output logic    w_ready,
  input  axil_w_t w,
  output logic    b_valid,
  input  logic    b_ready,
  // Memory side
  output logic    mem_ar_valid,
  input  logic    mem_ar_ready,
  output addr_t   mem_ar_addr,
  input  logic    mem_r_valid,
  output logic    mem_r_ready,
  input  data_t   mem_r_data,
  output logic    mem_aw_valid,
  input  logic    mem_aw_ready,
  output addr_t   mem_aw_addr,
  output logic    mem_w_valid,
  input  logic    mem_w_ready,
  output axil_w_t mem_w,
  input  logic    mem_b_valid,
  output logic    mem_b_ready
);

  line_info_t line;
  addr_t      lookup_addr;
  logic       wr_en;
  axil_w_t    wr_payload;
  logic       fill_en;
  data_t      fill_word;

  logic       start_wb;
  logic       start_fill;
  mem_cmd_t   cmd;
  logic       wb_done;
  logic       fill_done;
  data_t      fill_data;

  cache_ctrl cache_ctrl_i (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .ar_addr     (ar_addr),
    .r_valid     (r_valid),
    .r_ready     (r_ready),
    .r_data      (r_data),
    .aw_valid    (aw_valid),
    .aw_ready    (aw_ready),
    .aw_addr     (aw_addr),
    .w_valid     (w_valid),
    .w_ready     (w_ready),
    .w           (w),
    .b_valid     (b_valid),
    .b_ready     (b_ready),
    .line        (line),
    .lookup_addr (lookup_addr),
    .wr_en       (wr_en),
    .wr_payload  (wr_payload),
    .fill_en     (fill_en),
    .fill_word   (fill_word),
    .wb_done     (wb_done),
    .fill_done   (fill_done),
    .fill_data   (fill_data),
    .start_wb    (start_wb),
    .start_fill  (start_fill),
    .cmd         (cmd)
  );

  cache_store #(
    .num_sets (num_sets)
  ) cache_store_i (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .lookup_addr (lookup_addr),
    .wr_en       (wr_en),
    .wr_payload  (wr_payload),
    .fill_en     (fill_en),
    .fill_word   (fill_word),
    .line        (line)
  );

  mem_port mem_port_i (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .start_wb     (start_wb),
    .start_fill   (start_fill),
    .cmd          (cmd),
    .wb_done      (wb_done),
    .fill_done    (fill_done),
    .fill_data    (fill_data),
    .mem_ar_valid (mem_ar_valid),
    .mem_ar_ready (mem_ar_ready),
    .mem_ar_addr  (mem_ar_addr),
    .mem_r_valid  (mem_r_valid),
    .mem_r_ready  (mem_r_ready),
    .mem_r_data   (mem_r_data),
    .mem_aw_valid (mem_aw_valid),
    .mem_aw_ready (mem_aw_ready),
    .mem_aw_addr  (mem_aw_addr),
    .mem_w_valid  (mem_w_valid),
    .mem_w_ready  (mem_w_ready),
    .mem_w        (mem_w),
    .mem_b_valid  (mem_b_valid),
    .mem_b_ready  (mem_b_ready)
  );

endmodule

// File: verif/axil_mem_model.sv
`timescale 1ns/1ps

module axil_mem_model import axil_pkg::*; #(
  parameter data_t fill_key = '0
) (
  input  logic    ACLK,
  input  logic    ARESETn,
  input  logic    mem_ar_valid,
  output logic    mem_ar_ready,
  input  addr_t   mem_ar_addr,
  output logic    mem_r_valid,
  input  logic    mem_r_ready,
  output data_t   mem_r_data,
  input  logic    mem_aw_valid,
  output logic    mem_aw_ready,
  input  addr_t   mem_aw_addr,
  input  logic    mem_w_valid,
  output logic    mem_w_ready,
  input  axil_w_t mem_w,
  output logic    mem_b_valid,
  input  logic    mem_b_ready,
  // Transfer counters and the last write seen
  output int      ar_count,
  output int      aw_count,
  output int      w_count,
  output addr_t   last_aw_addr,
  output axil_w_t last_w
);

  data_t mem [addr_t];
  data_t word;
  addr_t rd_addr;
  int    ar_wait, r_wait, aw_wait, w_wait, b_wait;
  logic  r_pend, b_pend, have_aw, have_w;
  logic  ar_fire, r_fire, aw_fire, w_fire, b_fire;

  // Words never written read as their address XOR the key
  function automatic data_t peek(addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return a ^ fill_key;
  endfunction

  initial begin
    mem_ar_ready = 1'b0;
    mem_r_valid  = 1'b0;
    mem_r_data   = '0;
    mem_aw_ready = 1'b0;
    mem_w_ready  = 1'b0;
    mem_b_valid  = 1'b0;
    ar_count     = 0;
    aw_count     = 0;
    w_count      = 0;
    last_aw_addr = '0;
    last_w       = '0;
    rd_addr      = '0;
    r_pend       = 1'b0;
    b_pend       = 1'b0;
    have_aw      = 1'b0;
    have_w       = 1'b0;
    // The first request on each channel is taken without delay
    ar_wait      = 0;
    aw_wait      = 0;
    w_wait       = 0;
    r_wait       = 0;
    b_wait       = 0;
  end

  always @(posedge ACLK) begin
    // Transfers complete on this edge, so look before anything moves
    ar_fire = mem_ar_valid && mem_ar_ready;
    r_fire  = mem_r_valid && mem_r_ready;
    aw_fire = mem_aw_valid && mem_aw_ready;
    w_fire  = mem_w_valid && mem_w_ready;
    b_fire  = mem_b_valid && mem_b_ready;
    if (ar_fire) begin
      rd_addr = mem_ar_addr;
    end
    if (aw_fire) begin
      last_aw_addr = mem_aw_addr;
    end
    if (w_fire) begin
      last_w = mem_w;
    end
    #1;
    if (ARESETn) begin
      // Read address, then read data after its own delay
      if (ar_fire) begin
        mem_ar_ready = 1'b0;
        ar_count++;
        r_pend  = 1'b1;
        r_wait  = $urandom_range(3);
        ar_wait = $urandom_range(3);
      end else if (mem_ar_valid && !mem_ar_ready) begin
        if (ar_wait == 0) begin
          mem_ar_ready = 1'b1;
        end else begin
          ar_wait--;
        end
      end
      if (r_fire) begin
        mem_r_valid = 1'b0;
      end else if (r_pend) begin
        if (r_wait == 0) begin
          mem_r_valid = 1'b1;
          mem_r_data  = peek(rd_addr);
          r_pend      = 1'b0;
        end else begin
          r_wait--;
        end
      end

      // AW and W are accepted independently
      if (aw_fire) begin
        mem_aw_ready = 1'b0;
        aw_count++;
        have_aw = 1'b1;
        aw_wait = $urandom_range(3);
      end else if (mem_aw_valid && !mem_aw_ready) begin
        if (aw_wait == 0) begin
          mem_aw_ready = 1'b1;
        end else begin
          aw_wait--;
        end
      end
      if (w_fire) begin
        mem_w_ready = 1'b0;
        w_count++;
        have_w = 1'b1;
        w_wait = $urandom_range(3);
      end else if (mem_w_valid && !mem_w_ready) begin
        if (w_wait == 0) begin
          mem_w_ready = 1'b1;
        end else begin
          w_wait--;
        end
      end

      // Both halves in, so commit the strobed bytes and schedule B
      if (have_aw && have_w) begin
        word = peek(last_aw_addr);
        for (int b = 0; b < STRB_W; b++) begin
          if (last_w.strb[b]) begin
            word[8*b +: 8] = last_w.data[8*b +: 8];
          end
        end
        mem[last_aw_addr] = word;
        have_aw = 1'b0;
        have_w  = 1'b0;
        b_pend  = 1'b1;
        b_wait  = $urandom_range(3);
      end
      if (b_fire) begin
        mem_b_valid = 1'b0;
      end else if (b_pend) begin
        if (b_wait == 0) begin
          mem_b_valid = 1'b1;
          b_pend      = 1'b0;
        end else begin
          b_wait--;
        end
      end
    end
  end

endmodule

// File: verif/tb_axil_cache.sv
`timescale 1ns/1ps

module tb_axil_cache import axil_pkg::*; ();

  localparam data_t fill_key       = 32'h5a3c_96e1;
  localparam int    timeout_cycles = 4000;

  // With four sets, A and C share set 0, B is in set 1 and D in set 2
  localparam addr_t addr_a = 32'h0000_1000;
  localparam addr_t addr_b = 32'h0000_2004;
  localparam addr_t addr_c = 32'h0000_3000;
  localparam addr_t addr_d = 32'h0000_4008;

  logic    ACLK;
  logic    ARESETn;
  logic    ar_valid, ar_ready, r_valid, r_ready;
  logic    aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  addr_t   ar_addr, aw_addr;
  data_t   r_data;
  axil_w_t w;
  logic    mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_ready;
  logic    mem_aw_valid, mem_aw_ready, mem_w_valid, mem_w_ready;
  logic    mem_b_valid, mem_b_ready;
  addr_t   mem_ar_addr, mem_aw_addr;
  data_t   mem_r_data;
  axil_w_t mem_w;
  int      ar_count, aw_count, w_count;
  addr_t   last_aw_addr;
  axil_w_t last_w;

  int          val_errs;
  int          proto_errs;
  int          cycles;
  int unsigned seed;
  data_t       exp_a;

  axil_cache #(
    .num_sets (4)
  ) axil_cache_i (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .ar_addr      (ar_addr),
    .r_valid      (r_valid),
    .r_ready      (r_ready),
    .r_data       (r_data),
    .aw_valid     (aw_valid),
    .aw_ready     (aw_ready),
    .aw_addr      (aw_addr),
    .w_valid      (w_valid),
    .w_ready      (w_ready),
    .w            (w),
    .b_valid      (b_valid),
    .b_ready      (b_ready),
    .mem_ar_valid (mem_ar_valid),
    .mem_ar_ready (mem_ar_ready),
    .mem_ar_addr  (mem_ar_addr),
    .mem_r_valid  (mem_r_valid),
    .mem_r_ready  (mem_r_ready),
    .mem_r_data   (mem_r_data),
    .mem_aw_valid (mem_aw_valid),
    .mem_aw_ready (mem_aw_ready),
    .mem_aw_addr  (mem_aw_addr),
    .mem_w_valid  (mem_w_valid),
    .mem_w_ready  (mem_w_ready),
    .mem_w        (mem_w),
    .mem_b_valid  (mem_b_valid),
    .mem_b_ready  (mem_b_ready)
  );

  axil_mem_model #(
    .fill_key (fill_key)
  ) mem_model_i (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .mem_ar_valid (mem_ar_valid),
    .mem_ar_ready (mem_ar_ready),
    .mem_ar_addr  (mem_ar_addr),
    .mem_r_valid  (mem_r_valid),
    .mem_r_ready  (mem_r_ready),
    .mem_r_data   (mem_r_data),
    .mem_aw_valid (mem_aw_valid),
    .mem_aw_ready (mem_aw_ready),
    .mem_aw_addr  (mem_aw_addr),
    .mem_w_valid  (mem_w_valid),
    .mem_w_ready  (mem_w_ready),
    .mem_w        (mem_w),
    .mem_b_valid  (mem_b_valid),
    .mem_b_ready  (mem_b_ready),
    .ar_count     (ar_count),
    .aw_count     (aw_count),
    .w_count      (w_count),
    .last_aw_addr (last_aw_addr),
    .last_w       (last_w)
  );

  always #10 ACLK = ~ACLK;

  // About a dozen requests, none longer than ~40 cycles even with a writeback
  always @(posedge ACLK) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timeout after %0d cycles with %0d value errors and %0d protocol errors",
               cycles, val_errs, proto_errs);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic data_t initial_word(addr_t a);
    return a ^ fill_key;
  endfunction

  function automatic data_t apply_strobe(data_t old_word, data_t new_word, strb_t strb);
    data_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("ERR %s: got %h, expected %h at %0t", name, got, exp, $time);
    val_errs++;
  endtask

  task automatic protocol_error(input string msg);
    $display("%s at %0t", msg, $time);
    proto_errs++;
  endtask

  // Entered on the edge where the response valid is first seen
  task automatic hold_response(input logic is_read, input int stall);
    data_t held;
    held = r_data;
    for (int i = 1; i <= stall; i++) begin
      if (i == stall) begin
        #1;
        r_ready = 1'b1;
        b_ready = 1'b1;
      end
      @(posedge ACLK);
      if (is_read ? !r_valid : !b_valid) begin
        protocol_error("Response valid dropped before the handshake");
      end
      if (is_read && r_data !== held) mismatch("r_data", r_data, held);
      if (ar_ready || aw_ready) begin
        protocol_error("Processor ready came back before the response handshake");
      end
    end
    @(posedge ACLK);
    if (!ar_ready || !aw_ready || !w_ready) begin
      protocol_error("Processor readies not back the cycle after the handshake");
    end
    if (r_valid || b_valid) protocol_error("Response valid still high after the handshake");
    #1;
  endtask

  task automatic read_word(input addr_t addr, input int stall, output data_t data,
                           output int lat);
    ar_valid = 1'b1;
    ar_addr  = addr;
    r_ready  = (stall == 0);
    do @(posedge ACLK); while (!ar_ready);
    #1;
    ar_valid = 1'b0;
    lat = 0;
    do begin
      @(posedge ACLK);
      lat++;
    end while (!r_valid);
    data = r_data;
    hold_response(1'b1, stall);
  endtask

  task automatic write_word(input addr_t addr, input data_t data, input strb_t strb,
                            input int stall, output int lat);
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    aw_addr  = addr;
    w.data   = data;
    w.strb   = strb;
    b_ready  = (stall == 0);
    do @(posedge ACLK); while (!aw_ready);
    if (w_ready !== aw_ready) protocol_error("w_ready differs from aw_ready at acceptance");
    #1;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    lat = 0;
    do begin
      @(posedge ACLK);
      lat++;
    end while (!b_valid);
    hold_response(1'b0, stall);
  endtask

  task automatic idle_after_reset();
    @(posedge ACLK);
    if (!ar_ready || !aw_ready || !w_ready) protocol_error("Processor readies low after reset");
    if (r_valid || b_valid) protocol_error("Response valid high after reset");
    if (mem_ar_valid || mem_aw_valid || mem_w_valid) begin
      protocol_error("Memory-side valid high after reset");
    end
    #1;
  endtask

  task automatic read_miss_then_hit();
    data_t got;
    int    lat;
    int    ar_before;
    ar_before = ar_count;
    read_word(addr_a, 0, got, lat);
    if (got !== initial_word(addr_a)) mismatch("r_data", got, initial_word(addr_a));
    if (ar_count !== ar_before + 1) mismatch("ar_count", ar_count, ar_before + 1);
    read_word(addr_a, 0, got, lat);
    if (got !== initial_word(addr_a)) mismatch("r_data", got, initial_word(addr_a));
    if (ar_count !== ar_before + 1) mismatch("ar_count", ar_count, ar_before + 1);
    if (lat !== 1) mismatch("read hit latency", lat, 1);
    exp_a = initial_word(addr_a);
  endtask

  task automatic write_hit_partial();
    data_t got;
    int    lat;
    int    traffic;
    traffic = ar_count + aw_count + w_count;
    write_word(addr_a, 32'hdead_beef, 4'b0101, 0, lat);
    exp_a = apply_strobe(exp_a, 32'hdead_beef, 4'b0101);
    if (lat !== 1) mismatch("write hit latency", lat, 1);
    read_word(addr_a, 0, got, lat);
    if (got !== exp_a) mismatch("r_data", got, exp_a);
    if (ar_count + aw_count + w_count !== traffic) begin
      protocol_error("Memory transfer seen during write hit and read-back");
    end
  endtask

  task automatic write_miss_fill();
    data_t got;
    data_t exp_b;
    int    lat;
    int    ar_before;
    int    aw_before;
    ar_before = ar_count;
    aw_before = aw_count;
    write_word(addr_b, 32'h1234_5678, 4'b1100, 0, lat);
    exp_b = apply_strobe(initial_word(addr_b), 32'h1234_5678, 4'b1100);
    if (ar_count !== ar_before + 1) mismatch("ar_count", ar_count, ar_before + 1);
    if (aw_count !== aw_before) mismatch("aw_count", aw_count, aw_before);
    read_word(addr_b, 0, got, lat);
    if (got !== exp_b) mismatch("r_data", got, exp_b);
    if (ar_count !== ar_before + 1) mismatch("ar_count", ar_count, ar_before + 1);
  endtask

  task automatic dirty_eviction();
    data_t got;
    int    lat;
    int    ar_before;
    int    aw_before;
    int    w_before;
    ar_before = ar_count;
    aw_before = aw_count;
    w_before  = w_count;
    read_word(addr_c, 0, got, lat);
    if (got !== initial_word(addr_c)) mismatch("r_data", got, initial_word(addr_c));
    if (aw_count !== aw_before + 1) mismatch("aw_count", aw_count, aw_before + 1);
    if (w_count !== w_before + 1) mismatch("w_count", w_count, w_before + 1);
    if (ar_count !== ar_before + 1) mismatch("ar_count", ar_count, ar_before + 1);
    if (last_aw_addr !== addr_a) mismatch("mem_aw_addr", last_aw_addr, addr_a);
    if (last_w.data !== exp_a) mismatch("mem_w.data", last_w.data, exp_a);
    if (last_w.strb !== 4'hf) mismatch("mem_w.strb", last_w.strb, 4'hf);
    // A now lives only in the model, and C is clean so no second writeback
    read_word(addr_a, 0, got, lat);
    if (got !== exp_a) mismatch("r_data", got, exp_a);
    if (ar_count !== ar_before + 2) mismatch("ar_count", ar_count, ar_before + 2);
    if (aw_count !== aw_before + 1) mismatch("aw_count", aw_count, aw_before + 1);
  endtask

  task automatic response_backpressure();
    data_t got;
    int    lat;
    int    stall;
    stall = $urandom_range(6, 1);
    read_word(addr_a, stall, got, lat);
    if (got !== exp_a) mismatch("r_data", got, exp_a);
    if (lat !== 1) mismatch("read hit latency", lat, 1);
    stall = $urandom_range(6, 1);
    write_word(addr_a, 32'h0bad_f00d, 4'b1111, stall, lat);
    exp_a = apply_strobe(exp_a, 32'h0bad_f00d, 4'b1111);
    if (lat !== 1) mismatch("write hit latency", lat, 1);
    // Miss under back-pressure, data comes straight from the fill
    stall = $urandom_range(6, 1);
    read_word(addr_d, stall, got, lat);
    if (got !== initial_word(addr_d)) mismatch("r_data", got, initial_word(addr_d));
    read_word(addr_a, 0, got, lat);
    if (got !== exp_a) mismatch("r_data", got, exp_a);
  endtask

  initial begin
    seed = 98;
    void'($urandom(seed));
    val_errs   = 0;
    proto_errs = 0;
    cycles     = 0;
    exp_a      = '0;
    ACLK       = 1'b0;
    ARESETn    = 1'b0;
    ar_valid   = 1'b0;
    ar_addr    = '0;
    r_ready    = 1'b1;
    aw_valid   = 1'b0;
    aw_addr    = '0;
    w_valid    = 1'b0;
    w          = '0;
    b_ready    = 1'b1;
    repeat (8) @(posedge ACLK);
    #1;
    ARESETn = 1'b1;

    idle_after_reset();
    read_miss_then_hit();
    write_hit_partial();
    write_miss_fill();
    dirty_eviction();
    response_backpressure();

    $display("Run finished: %0d value errors, %0d protocol errors", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: list.f
hw/axil_pkg.sv
hw/cache_cfg_pkg.sv
hw/cache_store.sv
hw/cache_ctrl.sv
hw/mem_port.sv
hw/axil_cache.sv
verif/axil_mem_model.sv
verif/tb_axil_cache.sv

// File: Bender.yml
package:
  name: axil_cache

sources:
  - hw/axil_pkg.sv
  - hw/cache_cfg_pkg.sv
  - hw/cache_store.sv
  - hw/cache_ctrl.sv
  - hw/mem_port.sv
  - hw/axil_cache.sv
  - target: test
    files:
      - verif/axil_mem_model.sv
      - verif/tb_axil_cache.sv
